// ==== src/mem_bus_defines.svh ====
// Sizing macros for the memory subsystem
// Row count, array latency and line beat count

`ifndef MEM_BUS_DEFINES_SVH
`define MEM_BUS_DEFINES_SVH

// Row index width, 64 rows of 32 bytes
// The index comes from address bits 10..5
`define MEM_ROW_BITS 6

// Cycles from an array start to its done pulse
`define MEM_LATENCY 4

// 32-bit words in one 16-byte line
`define LINE_BEATS 4

`endif

// ==== src/mem_bus_pkg.sv ====
// Bus typedefs, unit and controller state enums, bus structs
`default_nettype none

`include "mem_bus_defines.svh"

package mem_bus_pkg;

   // Plain vectors with a meaning
   typedef logic [31:0]               bus_data_t;
   typedef logic [15:0]               bus_addr_t;
   typedef logic [11:0]               bus_size_t;
   typedef logic [127:0]              line_t;
   typedef logic [15:0]               line_mask_t;
   typedef logic [255:0]              row_t;
   typedef logic [31:0]               row_mask_t;
   typedef logic [`MEM_ROW_BITS-1:0]  row_idx_t;

   // Units that can sit on the bus
   typedef enum logic [1:0] {
      UNIT_IC,
      UNIT_DC,
      UNIT_MEM
   } unit_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SLV_ACK,
      ST_SLV_DATA,
      ST_MEM_BUSY,
      ST_BR,
      ST_MSTR_HDR,
      ST_MSTR_DATA
   } ctrl_state_t;

   // Header of a transfer, rw is high for a write
   typedef struct packed {
      logic       start;
      logic       rw;
      bus_addr_t  addr;
      bus_size_t  size;
      unit_t      dest;
      unit_t      src;
   } bus_ctrl_t;

   // What a master drives, also the shared bus itself
   typedef struct packed {
      bus_ctrl_t  ctrl;
      bus_data_t  data;
   } bus_drive_t;

endpackage

`default_nettype wire

// ==== src/mem_shiftleft.sv ====
// Byte shifter for a line and its byte mask
`timescale 1ns/10ps
`default_nettype none

module mem_shiftleft
   import mem_bus_pkg::*;
(
   input  wire logic [3:0]  amnt,
   input  wire line_t       din,
   input  wire line_mask_t  mask_in,
   output line_t            dout,
   output line_mask_t       mask_out
);

   line_t       stage1_data;
   line_mask_t  stage1_mask;

   // First stage moves 0..3 bytes
   always_comb
   begin
      stage1_data = din << {amnt[1:0], 3'b000};
      stage1_mask = mask_in << amnt[1:0];
   end

   // Second stage moves 0, 4, 8 or 12 bytes, upper bytes fall off
   always_comb
   begin
      dout     = stage1_data << {amnt[3:2], 5'b00000};
      mask_out = stage1_mask << {amnt[3:2], 2'b00};
   end

endmodule

`default_nettype wire

// ==== src/mem_line_buffer.sv ====
// Read row register and write line placement
// Builds the shifted write row and byte mask for the array
`timescale 1ns/10ps
`default_nettype none

module mem_line_buffer
   import mem_bus_pkg::*;
(
   input  wire logic        bus_clk,
   input  wire logic        rst_n,
   input  wire line_t       wr_line,
   input  wire bus_size_t   wr_len,
   input  wire logic [4:0]  offset,
   input  wire row_t        rd_row,
   input  wire logic        load,
   output row_t             wr_row,
   output row_mask_t        wr_mask,
   output line_t            rd_line
);

   line_mask_t  len_mask;
   line_t       shifted_line;
   line_mask_t  shifted_mask;
   row_t        row_q;

   // One enable bit per byte of the request, 16 gives a full line
   assign len_mask = line_mask_t'((17'h1 << wr_len[4:0]) - 17'h1);

   mem_shiftleft u_shift (
      .amnt     (offset[3:0]),
      .din      (wr_line),
      .mask_in  (len_mask),
      .dout     (shifted_line),
      .mask_out (shifted_mask)
   );

   //////////////////////////////////////////////////////////////////////
   // Write side
   //////////////////////////////////////////////////////////////////////

   // Data goes to both halves, the mask picks the real one
   assign wr_row  = {shifted_line, shifted_line};
   assign wr_mask = offset[4] ? {shifted_mask, 16'h0000} : {16'h0000, shifted_mask};

   //////////////////////////////////////////////////////////////////////
   // Read side
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
         row_q <= '0;
      else if (load)
         row_q <= rd_row;
   end

   // Half select by address bit 4
   assign rd_line = offset[4] ? row_q[255:128] : row_q[127:0];

endmodule

`default_nettype wire

// ==== src/mem_array.sv ====
// Byte-enabled row store with a one-hot latency timer
`timescale 1ns/10ps
`default_nettype none

`include "mem_bus_defines.svh"

module mem_array
   import mem_bus_pkg::*;
(
   input  wire logic       bus_clk,
   input  wire logic       rst_n,
   input  wire logic       mem_en,
   input  wire logic       mem_wr,
   input  wire row_idx_t   row,
   input  wire row_t       wr_row,
   input  wire row_mask_t  wr_mask,
   output row_t            rd_row,
   output logic            done
);

   localparam int ROWS = 1 << `MEM_ROW_BITS;

   row_t                    mem [ROWS];
   logic [`MEM_LATENCY:0]   timer;

   // Bit 0 is idle, the hot bit walks up once per cycle
   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
         timer <= (`MEM_LATENCY+1)'(1);
      else if (mem_en || !timer[0])
         timer <= {timer[`MEM_LATENCY-1:0], timer[`MEM_LATENCY]};
   end

   assign done = timer[`MEM_LATENCY];

   // Write lands on the done cycle
   always_ff @(posedge bus_clk)
   begin
      if (done && mem_wr)
      begin
         for (int b = 0; b < 32; b++)
         begin
            if (wr_mask[b])
               mem[row][8*b +: 8] <= wr_row[8*b +: 8];
         end
      end
   end

   // Read is sampled by the line buffer on done
   assign rd_row = mem[row];

endmodule

`default_nettype wire

// ==== src/mem_bus_fsm.sv ====
// Controller state register, next state and strobe decode
`timescale 1ns/10ps
`default_nettype none

module mem_bus_fsm
   import mem_bus_pkg::*;
(
   input  wire logic   bus_clk,
   input  wire logic   rst_n,
   input  wire logic   req_hit,
   input  wire logic   rw,
   input  wire logic   last_beat,
   input  wire logic   mem_done,
   input  wire logic   bg,
   input  wire logic   ack_in,
   output ctrl_state_t state,
   output logic        ack,
   output logic        br,
   output logic        mem_en,
   output logic        load_hdr,
   output logic        load_word,
   output logic        drive_hdr,
   output logic        drive_word
);

   ctrl_state_t  next_state;
   ctrl_state_t  prev_state;

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state      <= ST_IDLE;
         prev_state <= ST_IDLE;
      end
      else
      begin
         state      <= next_state;
         prev_state <= state;
      end
   end

   always_comb
   begin
      next_state = state;
      case (state)
         ST_IDLE:
            if (req_hit)
               next_state = ST_SLV_ACK;
         ST_SLV_ACK:
            next_state = rw ? ST_SLV_DATA : ST_MEM_BUSY;
         ST_SLV_DATA:
            if (last_beat)
               next_state = ST_MEM_BUSY;
         // Writes finish here, reads go on to the return
         ST_MEM_BUSY:
            if (mem_done)
               next_state = rw ? ST_IDLE : ST_BR;
         ST_BR:
            if (bg)
               next_state = ST_MSTR_HDR;
         ST_MSTR_HDR:
            if (ack_in)
               next_state = ST_MSTR_DATA;
         ST_MSTR_DATA:
            if (last_beat)
               next_state = ST_IDLE;
         default:
            next_state = ST_IDLE;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Strobes
   //////////////////////////////////////////////////////////////////////

   // Pulses
   assign load_hdr = (state == ST_IDLE) && req_hit;
   assign ack      = (state == ST_SLV_ACK);
   assign mem_en   = (state == ST_MEM_BUSY) && (prev_state != ST_MEM_BUSY);

   // Levels
   assign load_word  = (state == ST_SLV_DATA);
   assign br         = (state == ST_BR) || (state == ST_MSTR_HDR) ||
                       (state == ST_MSTR_DATA);
   assign drive_hdr  = (state == ST_MSTR_HDR);
   assign drive_word = (state == ST_MSTR_DATA);

endmodule

`default_nettype wire

// ==== src/mem_bus_controller.sv ====
// Memory bus controller datapath
// Header and write buffer registers, beat count, return drive
`timescale 1ns/10ps
`default_nettype none

`include "mem_bus_defines.svh"

module mem_bus_controller
   import mem_bus_pkg::*;
(
   input  wire logic        bus_clk,
   input  wire logic        rst_n,
   input  wire bus_drive_t  bus,
   input  wire logic        bg,
   input  wire logic        ack_in,
   input  wire line_t       rd_line,
   input  wire logic        mem_done,
   output bus_drive_t       mem_out,
   output logic             br,
   output logic             ack,
   output logic             mem_en,
   output logic             mem_wr,
   output row_idx_t         row,
   output line_t            wr_line,
   output bus_size_t        wr_len,
   output logic [4:0]       offset,
   output logic             rd_load
);

   localparam int BEAT_W = $clog2(`LINE_BEATS);

   ctrl_state_t        state;
   logic               req_hit;
   logic               last_beat;
   logic               load_hdr;
   logic               load_word;
   logic               drive_hdr;
   logic               drive_word;

   bus_addr_t          addr_q;
   bus_size_t          size_q;
   logic               rw_q;
   unit_t              src_q;
   logic [BEAT_W-1:0]  beat_q;
   line_t              wbuf_q;

   // A request for us shows start with dest memory
   assign req_hit = bus.ctrl.start && (bus.ctrl.dest == UNIT_MEM);

   mem_bus_fsm u_fsm (
      .bus_clk    (bus_clk),
      .rst_n      (rst_n),
      .req_hit    (req_hit),
      .rw         (rw_q),
      .last_beat  (last_beat),
      .mem_done   (mem_done),
      .bg         (bg),
      .ack_in     (ack_in),
      .state      (state),
      .ack        (ack),
      .br         (br),
      .mem_en     (mem_en),
      .load_hdr   (load_hdr),
      .load_word  (load_word),
      .drive_hdr  (drive_hdr),
      .drive_word (drive_word)
   );

   //////////////////////////////////////////////////////////////////////
   // Request header and beat counter
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         addr_q <= '0;
         size_q <= '0;
         rw_q   <= 1'b0;
         src_q  <= UNIT_IC;
      end
      else if (load_hdr)
      begin
         addr_q <= bus.ctrl.addr;
         size_q <= bus.ctrl.size;
         rw_q   <= bus.ctrl.rw;
         src_q  <= bus.ctrl.src;
      end
   end

   // Counts write words in, then return words out
   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
         beat_q <= '0;
      else if (load_hdr || (state == ST_MSTR_HDR))
         beat_q <= '0;
      else if (load_word || drive_word)
         beat_q <= beat_q + 1'b1;
   end

   // Return is always a full line, writes stop at size/4 words
   assign last_beat = drive_word ? (beat_q == BEAT_W'(`LINE_BEATS - 1)) :
                                   (10'(beat_q) == size_q[11:2] - 10'd1);

   // Each write word lands at its beat index
   always_ff @(posedge bus_clk)
   begin
      if (load_word)
         wbuf_q[32*beat_q +: 32] <= bus.data;
   end

   //////////////////////////////////////////////////////////////////////
   // Array side and return drive
   //////////////////////////////////////////////////////////////////////

   assign mem_wr  = rw_q;
   assign row     = addr_q[10:5];
   assign offset  = addr_q[4:0];
   assign wr_line = wbuf_q;
   assign wr_len  = size_q;
   assign rd_load = mem_done && !rw_q && (state == ST_MEM_BUSY);

   always_comb
   begin
      mem_out = '0;
      if (drive_hdr || drive_word)
      begin
         mem_out.ctrl.start = drive_hdr;
         mem_out.ctrl.rw    = 1'b1;
         mem_out.ctrl.addr  = {addr_q[15:4], 4'h0};
         mem_out.ctrl.size  = 12'd16;
         mem_out.ctrl.dest  = src_q;
         mem_out.ctrl.src   = UNIT_MEM;
      end
      // Word 0 carries the lowest bytes
      if (drive_word)
         mem_out.data = rd_line[32*beat_q +: 32];
   end

endmodule

`default_nettype wire

// ==== src/bus_arbiter.sv ====
// Fixed-priority bus arbiter and bus steering
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter
   import mem_bus_pkg::*;
(
   input  wire logic        bus_clk,
   input  wire logic        rst_n,
   input  wire logic        mem_br,
   input  wire logic        dc_br,
   input  wire logic        ic_br,
   input  wire bus_drive_t  mem_drv,
   input  wire bus_drive_t  dc_drv,
   input  wire bus_drive_t  ic_drv,
   output logic             mem_bg,
   output logic             dc_bg,
   output logic             ic_bg,
   output bus_drive_t       bus
);

   // One-hot grant, {mem, dc, ic}
   logic [2:0]  grant_q;

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
         grant_q <= 3'b000;
      else if (grant_q == 3'b000)
      begin
         if (mem_br)
            grant_q <= 3'b100;
         else if (dc_br)
            grant_q <= 3'b010;
         else if (ic_br)
            grant_q <= 3'b001;
      end
      // Holder let go of br
      else if ((grant_q & {mem_br, dc_br, ic_br}) == 3'b000)
         grant_q <= 3'b000;
   end

   assign mem_bg = grant_q[2];
   assign dc_bg  = grant_q[1];
   assign ic_bg  = grant_q[0];

   always_comb
   begin
      case (grant_q)
         3'b100:  bus = mem_drv;
         3'b010:  bus = dc_drv;
         3'b001:  bus = ic_drv;
         default: bus = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== src/mem_subsystem_top.sv ====
// Memory subsystem top
// Arbiter, bus controller, line buffer and row array
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem_top
   import mem_bus_pkg::*;
(
   input  wire logic        bus_clk,
   input  wire logic        rst_n,
   input  wire logic        ic_br,
   input  wire logic        dc_br,
   input  wire bus_drive_t  ic_drv,
   input  wire bus_drive_t  dc_drv,
   input  wire logic        ack_in,
   output logic             ic_bg,
   output logic             dc_bg,
   output logic             mem_ack,
   output bus_drive_t       bus
);

   logic         mem_br;
   logic         mem_bg;
   bus_drive_t   mem_drv;
   logic         mem_en;
   logic         mem_wr;
   logic         mem_done;
   row_idx_t     row;
   line_t        wr_line;
   bus_size_t    wr_len;
   logic [4:0]   offset;
   logic         rd_load;
   line_t        rd_line;
   row_t         arr_rd_row;
   row_t         wr_row;
   row_mask_t    wr_mask;

   bus_arbiter u_arbiter (
      .bus_clk (bus_clk),
      .rst_n   (rst_n),
      .mem_br  (mem_br),
      .dc_br   (dc_br),
      .ic_br   (ic_br),
      .mem_drv (mem_drv),
      .dc_drv  (dc_drv),
      .ic_drv  (ic_drv),
      .mem_bg  (mem_bg),
      .dc_bg   (dc_bg),
      .ic_bg   (ic_bg),
      .bus     (bus)
   );

   mem_bus_controller u_ctrl (
      .bus_clk  (bus_clk),
      .rst_n    (rst_n),
      .bus      (bus),
      .bg       (mem_bg),
      .ack_in   (ack_in),
      .rd_line  (rd_line),
      .mem_done (mem_done),
      .mem_out  (mem_drv),
      .br       (mem_br),
      .ack      (mem_ack),
      .mem_en   (mem_en),
      .mem_wr   (mem_wr),
      .row      (row),
      .wr_line  (wr_line),
      .wr_len   (wr_len),
      .offset   (offset),
      .rd_load  (rd_load)
   );

   mem_line_buffer u_line_buf (
      .bus_clk (bus_clk),
      .rst_n   (rst_n),
      .wr_line (wr_line),
      .wr_len  (wr_len),
      .offset  (offset),
      .rd_row  (arr_rd_row),
      .load    (rd_load),
      .wr_row  (wr_row),
      .wr_mask (wr_mask),
      .rd_line (rd_line)
   );

   mem_array u_array (
      .bus_clk (bus_clk),
      .rst_n   (rst_n),
      .mem_en  (mem_en),
      .mem_wr  (mem_wr),
      .row     (row),
      .wr_row  (wr_row),
      .wr_mask (wr_mask),
      .rd_row  (arr_rd_row),
      .done    (mem_done)
   );

endmodule

`default_nettype wire

// ==== test/tb_bus_agent.svh ====
// Cache master tasks for the shared memory bus
// Byte-level model of the memory contents
`ifndef TB_BUS_AGENT_SVH
`define TB_BUS_AGENT_SVH

// Expected memory contents, one entry per byte address
logic [7:0] model_mem [2048];

task automatic drive_master(input unit_t unit, input logic br, input bus_drive_t drv);
   if (unit == UNIT_IC)
   begin
      ic_br  = br;
      ic_drv = drv;
   end
   else
   begin
      dc_br  = br;
      dc_drv = drv;
   end
endtask

task automatic wait_grant(input unit_t unit);
   int n;
   n = 0;
   do
   begin
      @(negedge bus_clk);
      n++;
      if (n > 100)
         abort_run("a bus grant");
   end while (!((unit == UNIT_IC) ? ic_bg : dc_bg));
endtask

task automatic wait_ack(output int waited);
   int n;
   n = 0;
   do
   begin
      @(negedge bus_clk);
      n++;
      if (n > 100)
         abort_run("the memory ack");
   end while (!mem_ack);
   waited = n;
endtask

task automatic bus_write(input unit_t unit, input bus_addr_t addr, input bus_size_t size,
                         input bus_data_t seed, output int waited);
   bus_drive_t drv;
   bus_data_t  w;
   int         idx;
   drv = '0;
   drive_master(unit, 1'b1, drv);
   wait_grant(unit);
   drv.ctrl = '{start: 1'b1, rw: 1'b1, addr: addr, size: size, dest: UNIT_MEM, src: unit};
   drive_master(unit, 1'b1, drv);
   wait_ack(waited);
   drv.ctrl.start = 1'b0;
   drive_master(unit, 1'b1, drv);
   for (int k = 0; k < int'(size) / 4; k++)
   begin
      @(negedge bus_clk);
      w = seed ^ $urandom();
      drv.data = w;
      drive_master(unit, 1'b1, drv);
      // Shift by the byte offset, bytes past 15 are lost
      for (int b = 0; b < 4; b++)
      begin
         idx = int'(addr[3:0]) + 4 * k + b;
         if (idx < 16)
            model_mem[int'(addr[10:4]) * 16 + idx] = w[8*b +: 8];
      end
   end
   @(negedge bus_clk);
   drive_master(unit, 1'b0, '0);
endtask

task automatic bus_read_req(input unit_t unit, input bus_addr_t addr, input int hold,
                            output int waited, output realtime t_start);
   bus_drive_t drv;
   drv = '0;
   drive_master(unit, 1'b1, drv);
   wait_grant(unit);
   t_start = $realtime;
   drv.ctrl = '{start: 1'b1, rw: 1'b0, addr: addr, size: 12'd16, dest: UNIT_MEM, src: unit};
   drive_master(unit, 1'b1, drv);
   wait_ack(waited);
   drv.ctrl.start = 1'b0;
   drive_master(unit, 1'b1, drv);
   // Optionally keep the bus for a while with nothing on it
   repeat (hold)
      @(negedge bus_clk);
   drive_master(unit, 1'b0, '0);
endtask

task automatic collect_return(input unit_t unit, input bus_addr_t addr, output realtime t_hdr);
   int n;
   int base;
   n = 0;
   base = int'(addr[10:4]) * 16;
   do
   begin
      @(negedge bus_clk);
      n++;
      if (n > 100)
         abort_run("the return header");
   end while (!(bus.ctrl.start && bus.ctrl.dest == unit && bus.ctrl.src == UNIT_MEM));
   t_hdr = $realtime;
   check_eq("bus.ctrl.rw", 32'(bus.ctrl.rw), 32'd1);
   check_eq("bus.ctrl.addr", 32'(bus.ctrl.addr), 32'({addr[15:4], 4'h0}));
   check_eq("bus.ctrl.size", 32'(bus.ctrl.size), 32'd16);
   ack_in = 1'b1;
   for (int k = 0; k < `LINE_BEATS; k++)
   begin
      @(negedge bus_clk);
      ack_in = 1'b0;
      check_eq($sformatf("bus.data[%0d]", k), bus.data,
               {model_mem[base+4*k+3], model_mem[base+4*k+2],
                model_mem[base+4*k+1], model_mem[base+4*k]});
   end
endtask

`endif

// ==== test/tb_mem_subsystem.sv ====
// Testbench for the memory subsystem
// Table-driven writes and reads, back-pressure and arbitration
`timescale 1ns/10ps
`default_nettype none

`include "mem_bus_defines.svh"

module tb_mem_subsystem
   import mem_bus_pkg::*;
();

   typedef struct packed {
      unit_t      unit;
      logic       rw;
      bus_addr_t  addr;
      bus_size_t  size;
      bus_data_t  seed;
   } test_entry_t;

   localparam int NUM_TESTS = 9;

   // Full lines first so every byte read back has a known value
   localparam test_entry_t TESTS [NUM_TESTS] = '{
      '{UNIT_DC, 1'b1, 16'h0040, 12'd16, 32'h1234_5678},
      '{UNIT_DC, 1'b0, 16'h0040, 12'd16, 32'h0},
      '{UNIT_DC, 1'b1, 16'h0050, 12'd16, 32'h9abc_def0},
      '{UNIT_DC, 1'b1, 16'h0043, 12'd4,  32'h0f0f_0f0f},
      '{UNIT_DC, 1'b1, 16'h004e, 12'd8,  32'hcafe_f00d},
      '{UNIT_DC, 1'b0, 16'h0046, 12'd16, 32'h0},
      '{UNIT_IC, 1'b0, 16'h0050, 12'd16, 32'h0},
      '{UNIT_IC, 1'b1, 16'h0059, 12'd8,  32'h5a5a_a5a5},
      '{UNIT_IC, 1'b0, 16'h005c, 12'd16, 32'h0}
   };

   logic        bus_clk;
   logic        rst_n;
   logic        ic_br;
   logic        dc_br;
   bus_drive_t  ic_drv;
   bus_drive_t  dc_drv;
   logic        ack_in;
   logic        ic_bg;
   logic        dc_bg;
   logic        mem_ack;
   bus_drive_t  bus;

   int errors;
   int checks;
   int tests;

   mem_subsystem_top dut (
      .bus_clk (bus_clk),
      .rst_n   (rst_n),
      .ic_br   (ic_br),
      .dc_br   (dc_br),
      .ic_drv  (ic_drv),
      .dc_drv  (dc_drv),
      .ack_in  (ack_in),
      .ic_bg   (ic_bg),
      .dc_bg   (dc_bg),
      .mem_ack (mem_ack),
      .bus     (bus)
   );

   always #4 bus_clk = ~bus_clk;

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_true(input logic ok, input string what);
      checks++;
      assert (ok)
      else
      begin
         errors++;
         $display("FAIL t=%0t %s", $time, what);
      end
   endtask

   task automatic abort_run(input string what);
      $display("ERROR: timed out waiting for %s", what);
      $display("SIMULATION FAILED");
      $finish;
   endtask

   task automatic report_test(input string what, input int errs_before);
      tests++;
      $display("test %0d %s: %s", tests, what, (errors == errs_before) ? "ok" : "errors");
   endtask

   `include "tb_bus_agent.svh"

   initial
   begin
      int          waited;
      int          waited_dc;
      int          errs;
      realtime     t_start;
      realtime     t_hdr;
      realtime     t_dc;
      test_entry_t t;
      bus_clk = 1'b0;
      rst_n   = 1'b0;
      ic_br   = 1'b0;
      dc_br   = 1'b0;
      ic_drv  = '0;
      dc_drv  = '0;
      ack_in  = 1'b0;
      errors  = 0;
      checks  = 0;
      tests   = 0;
      void'($urandom(82));
      repeat (2)
         @(posedge bus_clk);
      @(negedge bus_clk);
      rst_n = 1'b1;

      errs = errors;
      check_eq("mem_ack", 32'(mem_ack), 32'd0);
      check_eq("ic_bg", 32'(ic_bg), 32'd0);
      check_eq("dc_bg", 32'(dc_bg), 32'd0);
      check_eq("bus.ctrl.start", 32'(bus.ctrl.start), 32'd0);
      report_test("reset state", errs);

      //////////////////////////////////////////////////////////////////////
      // Table of writes and reads
      //////////////////////////////////////////////////////////////////////
      for (int i = 0; i < NUM_TESTS; i++)
      begin
         t = TESTS[i];
         errs = errors;
         if (t.rw)
            bus_write(t.unit, t.addr, t.size, t.seed, waited);
         else
         begin
            bus_read_req(t.unit, t.addr, 0, waited, t_start);
            collect_return(t.unit, t.addr, t_hdr);
         end
         report_test($sformatf("%s %s addr %h size %0d", t.unit.name(),
                               t.rw ? "write" : "read", t.addr, t.size), errs);
      end

      // Second request held while the memory finishes a write
      errs = errors;
      bus_write(UNIT_DC, 16'h0060, 12'd16, 32'h3c3c_7e7e, waited);
      bus_write(UNIT_IC, 16'h0066, 12'd4, 32'h1111_2222, waited);
      check_true(waited > 1, "ic request was acked while the memory was busy");
      bus_read_req(UNIT_DC, 16'h0060, 0, waited, t_start);
      collect_return(UNIT_DC, 16'h0060, t_hdr);
      report_test("back-pressure", errs);

      // Memory return and a dc request pending together
      errs  = errors;
      t_hdr = 0;
      fork
         begin
            bus_read_req(UNIT_IC, 16'h0050, 20, waited, t_start);
            collect_return(UNIT_IC, 16'h0050, t_hdr);
         end
         begin
            wait_grant(UNIT_IC);
            drive_master(UNIT_DC, 1'b1, '0);
            wait_grant(UNIT_DC);
            t_dc = $realtime;
            check_true(t_hdr > 0 && t_hdr < t_dc,
                       "dc was granted the bus before the memory return header");
            bus_read_req(UNIT_DC, 16'h0040, 0, waited_dc, t_start);
         end
      join
      collect_return(UNIT_DC, 16'h0040, t_hdr);
      report_test("arbitration", errs);

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+src
+incdir+test
src/mem_bus_pkg.sv
src/mem_shiftleft.sv
src/mem_line_buffer.sv
src/mem_array.sv
src/mem_bus_fsm.sv
src/mem_bus_controller.sv
src/bus_arbiter.sv
src/mem_subsystem_top.sv
test/tb_mem_subsystem.sv

// ==== Makefile ====
TOP = tb_mem_subsystem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf obj_dir
